// ==== mipsCore_config.svh ====
`ifndef MIPS_CORE_CONFIG_SVH
`define MIPS_CORE_CONFIG_SVH

// data memory size in 32-bit words
`define MIPS_DMEM_WORDS 64

// word address width as log2 of the depth
`define MIPS_DMEM_AW 6

// general purpose register file
`define MIPS_NUM_REGS 32

`endif

// ==== mipsPkg.sv ====
`default_nettype none

`include "mipsCore_config.svh"

package mipsPkg;

    // primary opcodes
    localparam logic [5:0] opSpecial  = 6'b000000;
    localparam logic [5:0] opSpecial2 = 6'b011100;
    localparam logic [5:0] opAddi     = 6'b001000;
    localparam logic [5:0] opAndi     = 6'b001100;
    localparam logic [5:0] opOri      = 6'b001101;
    localparam logic [5:0] opXori     = 6'b001110;
    localparam logic [5:0] opLui      = 6'b001111;
    localparam logic [5:0] opLb       = 6'b100000;
    localparam logic [5:0] opLh       = 6'b100001;
    localparam logic [5:0] opLw       = 6'b100011;
    localparam logic [5:0] opSb       = 6'b101000;
    localparam logic [5:0] opSh       = 6'b101001;
    localparam logic [5:0] opSw       = 6'b101011;

    // funct codes under opSpecial
    localparam logic [5:0] fnSll   = 6'b000000;
    localparam logic [5:0] fnMfhi  = 6'b010000;
    localparam logic [5:0] fnMthi  = 6'b010001;
    localparam logic [5:0] fnMflo  = 6'b010010;
    localparam logic [5:0] fnMtlo  = 6'b010011;
    localparam logic [5:0] fnMult  = 6'b011000;
    localparam logic [5:0] fnMultu = 6'b011001;
    localparam logic [5:0] fnDiv   = 6'b011010;
    localparam logic [5:0] fnDivu  = 6'b011011;
    localparam logic [5:0] fnAdd   = 6'b100000;
    localparam logic [5:0] fnSub   = 6'b100010;
    localparam logic [5:0] fnAnd   = 6'b100100;
    localparam logic [5:0] fnOr    = 6'b100101;
    localparam logic [5:0] fnXor   = 6'b100110;
    localparam logic [5:0] fnSlt   = 6'b101010;
    localparam logic [5:0] fnSltu  = 6'b101011;

    // funct codes under opSpecial2
    localparam logic [5:0] fnMadd  = 6'b000000;
    localparam logic [5:0] fnMaddu = 6'b000001;
    localparam logic [5:0] fnMsub  = 6'b000100;
    localparam logic [5:0] fnMsubu = 6'b000101;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFieldsT;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iFieldsT;

    // same word seen as R-type or I-type
    typedef union packed {
        rFieldsT r;
        iFieldsT i;
    } instrT;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSll, aluSlt, aluSltu
    } aluOpT;

    typedef enum logic [3:0] {
        mduNone, mduMult, mduMultu, mduDiv, mduDivu, mduMfhi, mduMflo,
        mduMthi, mduMtlo, mduMadd, mduMaddu, mduMsub, mduMsubu
    } mduOpT;

    typedef enum logic [1:0] {extZero, extSign, extUpper} extOpT;

    typedef enum logic [1:0] {wbAlu, wbMem, wbExt, wbMdu} wbSrcT;

    typedef enum logic [1:0] {accNone, accByte, accHalf, accWord} accSizeT;

    typedef struct packed {
        aluOpT      aluOp;
        logic       aluSrcImm;
        extOpT      extOp;
        logic       regWrite;
        logic [4:0] regAddr;
        wbSrcT      wbSrc;
        mduOpT      mduOp;
        logic       memWrite;
        accSizeT    storeSize;
        accSizeT    loadSize;
    } ctrlT;

    typedef struct packed {
        logic [4:0]  addr;
        logic [31:0] data;
    } wbReportT;

    typedef struct packed {
        logic [`MIPS_DMEM_AW-1:0] wordAddr;
        logic [3:0]               byteEn;
        logic [31:0]              data;
    } memReportT;

endpackage

`default_nettype wire

// ==== instrDecoder.sv ====
`default_nettype none

module instrDecoder (
    input  mipsPkg::instrT instr,
    output mipsPkg::ctrlT  ctrl
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic isR;
    logic isR2;
    logic add, sub, sll, isAnd, isOr, isXor, slt, sltu;
    logic addi, andi, ori, xori, lui;
    logic mult, multu, div, divu, madd, maddu, msub, msubu;
    logic mfhi, mflo, mthi, mtlo;
    logic lb, lh, lw, sb, sh, sw;
    logic calcR, calcI, load, store, mf;

    assign opcode = instr.r.opcode;
    assign funct  = instr.r.funct;

    assign isR  = (opcode == mipsPkg::opSpecial);
    assign isR2 = (opcode == mipsPkg::opSpecial2);

    // R-type arithmetic
    assign add   = isR & (funct == mipsPkg::fnAdd);
    assign sub   = isR & (funct == mipsPkg::fnSub);
    assign sll   = isR & (funct == mipsPkg::fnSll);
    assign isAnd = isR & (funct == mipsPkg::fnAnd);
    assign isOr  = isR & (funct == mipsPkg::fnOr);
    assign isXor = isR & (funct == mipsPkg::fnXor);
    assign slt   = isR & (funct == mipsPkg::fnSlt);
    assign sltu  = isR & (funct == mipsPkg::fnSltu);

    // hi/lo group
    assign mult  = isR & (funct == mipsPkg::fnMult);
    assign multu = isR & (funct == mipsPkg::fnMultu);
    assign div   = isR & (funct == mipsPkg::fnDiv);
    assign divu  = isR & (funct == mipsPkg::fnDivu);
    assign mfhi  = isR & (funct == mipsPkg::fnMfhi);
    assign mflo  = isR & (funct == mipsPkg::fnMflo);
    assign mthi  = isR & (funct == mipsPkg::fnMthi);
    assign mtlo  = isR & (funct == mipsPkg::fnMtlo);
    assign madd  = isR2 & (funct == mipsPkg::fnMadd);
    assign maddu = isR2 & (funct == mipsPkg::fnMaddu);
    assign msub  = isR2 & (funct == mipsPkg::fnMsub);
    assign msubu = isR2 & (funct == mipsPkg::fnMsubu);

    // immediates and memory
    assign addi = (opcode == mipsPkg::opAddi);
    assign andi = (opcode == mipsPkg::opAndi);
    assign ori  = (opcode == mipsPkg::opOri);
    assign xori = (opcode == mipsPkg::opXori);
    assign lui  = (opcode == mipsPkg::opLui);
    assign lb   = (opcode == mipsPkg::opLb);
    assign lh   = (opcode == mipsPkg::opLh);
    assign lw   = (opcode == mipsPkg::opLw);
    assign sb   = (opcode == mipsPkg::opSb);
    assign sh   = (opcode == mipsPkg::opSh);
    assign sw   = (opcode == mipsPkg::opSw);

    assign calcR = add | sub | isAnd | isOr | isXor | sll | slt | sltu;
    assign calcI = addi | andi | ori | xori;
    assign load  = lb | lh | lw;
    assign store = sb | sh | sw;
    assign mf    = mfhi | mflo;

    always_comb begin
        ctrl = '0;

        ctrl.aluOp = sub            ? mipsPkg::aluSub :
                     (isAnd | andi) ? mipsPkg::aluAnd :
                     (isOr | ori)   ? mipsPkg::aluOr :
                     (isXor | xori) ? mipsPkg::aluXor :
                     sll            ? mipsPkg::aluSll :
                     slt            ? mipsPkg::aluSlt :
                     sltu           ? mipsPkg::aluSltu :
                     mipsPkg::aluAdd;

        // loads and stores use the alu for the address
        ctrl.aluSrcImm = calcI | load | store;

        ctrl.extOp = (load | store | addi) ? mipsPkg::extSign :
                     lui                   ? mipsPkg::extUpper :
                     mipsPkg::extZero;

        ctrl.regWrite = calcR | calcI | load | lui | mf;
        ctrl.regAddr  = (calcR | mf)               ? instr.r.rd :
                        (calcI | load | lui)       ? instr.i.rt :
                        5'd0;

        ctrl.wbSrc = load ? mipsPkg::wbMem :
                     lui  ? mipsPkg::wbExt :
                     mf   ? mipsPkg::wbMdu :
                     mipsPkg::wbAlu;

        ctrl.mduOp = mult  ? mipsPkg::mduMult :
                     multu ? mipsPkg::mduMultu :
                     div   ? mipsPkg::mduDiv :
                     divu  ? mipsPkg::mduDivu :
                     mfhi  ? mipsPkg::mduMfhi :
                     mflo  ? mipsPkg::mduMflo :
                     mthi  ? mipsPkg::mduMthi :
                     mtlo  ? mipsPkg::mduMtlo :
                     madd  ? mipsPkg::mduMadd :
                     maddu ? mipsPkg::mduMaddu :
                     msub  ? mipsPkg::mduMsub :
                     msubu ? mipsPkg::mduMsubu :
                     mipsPkg::mduNone;

        ctrl.memWrite  = store;
        ctrl.storeSize = sw ? mipsPkg::accWord :
                         sh ? mipsPkg::accHalf :
                         sb ? mipsPkg::accByte :
                         mipsPkg::accNone;
        ctrl.loadSize  = lw ? mipsPkg::accWord :
                         lh ? mipsPkg::accHalf :
                         lb ? mipsPkg::accByte :
                         mipsPkg::accNone;
    end

endmodule

`default_nettype wire

// ==== regFile.sv ====
`default_nettype none

`include "mipsCore_config.svh"

module regFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    input  logic [4:0]  raddrA,
    input  logic [4:0]  raddrB,
    output logic [31:0] rdataA,
    output logic [31:0] rdataB
);

    logic [31:0] regs [`MIPS_NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            // r0 stays zero
            regs[waddr] <= wdata;
        end
    end

    assign rdataA = regs[raddrA];
    assign rdataB = regs[raddrB];

endmodule

`default_nettype wire

// ==== aluUnit.sv ====
`default_nettype none

module aluUnit (
    input  mipsPkg::aluOpT op,
    input  logic [31:0]    a,
    input  logic [31:0]    b,
    input  logic [4:0]     shamt,
    output logic [31:0]    y
);

    always_comb begin
        case (op)
            mipsPkg::aluAdd: y = a + b;
            mipsPkg::aluSub: y = a - b;
            mipsPkg::aluAnd: y = a & b;
            mipsPkg::aluOr:  y = a | b;
            mipsPkg::aluXor: y = a ^ b;
            // sll shifts the rt operand
            mipsPkg::aluSll: y = b << shamt;
            mipsPkg::aluSlt: begin
                y = {31'd0, $signed(a) < $signed(b)};
            end
            mipsPkg::aluSltu: begin
                y = {31'd0, a < b};
            end
            default: y = a + b;
        endcase
    end

endmodule

`default_nettype wire

// ==== mulDivUnit.sv ====
`default_nettype none

module mulDivUnit (
    input  logic           clk,
    input  logic           rstN,
    input  logic           en,
    input  mipsPkg::mduOpT op,
    input  logic [31:0]    a,
    input  logic [31:0]    b,
    output logic [31:0]    hiLoOut
);

    logic [31:0] hi;
    logic [31:0] lo;
    logic [63:0] sProd;
    logic [63:0] uProd;
    logic [63:0] hiLo;
    logic [31:0] sQuot;
    logic [31:0] sRem;

    assign hiLo  = {hi, lo};
    assign sProd = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
    assign uProd = {32'd0, a} * {32'd0, b};
    assign sQuot = $signed(a) / $signed(b);
    assign sRem  = $signed(a) % $signed(b);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            hi <= '0;
            lo <= '0;
        end else if (en) begin
            case (op)
                mipsPkg::mduMult:  {hi, lo} <= sProd;
                mipsPkg::mduMultu: {hi, lo} <= uProd;
                mipsPkg::mduDiv: begin
                    // divide by zero keeps hi/lo
                    if (b != 32'd0) begin
                        lo <= sQuot;
                        hi <= sRem;
                    end
                end
                mipsPkg::mduDivu: begin
                    if (b != 32'd0) begin
                        lo <= a / b;
                        hi <= a % b;
                    end
                end
                mipsPkg::mduMadd:  {hi, lo} <= hiLo + sProd;
                mipsPkg::mduMaddu: {hi, lo} <= hiLo + uProd;
                mipsPkg::mduMsub:  {hi, lo} <= hiLo - sProd;
                mipsPkg::mduMsubu: {hi, lo} <= hiLo - uProd;
                mipsPkg::mduMthi:  hi <= a;
                mipsPkg::mduMtlo:  lo <= a;
                default: ;
            endcase
        end
    end

    assign hiLoOut = (op == mipsPkg::mduMfhi) ? hi : lo;

endmodule

`default_nettype wire

// ==== dataMem.sv ====
`default_nettype none

`include "mipsCore_config.svh"

module dataMem (
    input  logic               clk,
    input  logic               en,
    input  logic [31:0]        addr,
    input  logic [31:0]        wdata,
    input  mipsPkg::accSizeT   storeSize,
    input  mipsPkg::accSizeT   loadSize,
    output logic [31:0]        loadData,
    output mipsPkg::memReportT storeReport
);

    logic [31:0]              mem [`MIPS_DMEM_WORDS];
    logic [`MIPS_DMEM_AW-1:0] wordAddr;
    logic [31:0]              rdWord;
    logic [31:0]              laneData;
    logic [3:0]               byteEn;
    logic [31:0]              merged;
    logic [7:0]               ldByte;
    logic [15:0]              ldHalf;

    // upper address bits beyond the depth are dropped
    assign wordAddr = addr[`MIPS_DMEM_AW+1:2];
    assign rdWord   = mem[wordAddr];

    always_comb begin
        case (storeSize)
            mipsPkg::accByte: begin
                byteEn   = 4'b0001 << addr[1:0];
                laneData = {4{wdata[7:0]}};
            end
            mipsPkg::accHalf: begin
                byteEn   = addr[1] ? 4'b1100 : 4'b0011;
                laneData = {2{wdata[15:0]}};
            end
            mipsPkg::accWord: begin
                byteEn   = 4'b1111;
                laneData = wdata;
            end
            default: begin
                byteEn   = 4'b0000;
                laneData = wdata;
            end
        endcase
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            merged[8*i +: 8] = byteEn[i] ? laneData[8*i +: 8] : rdWord[8*i +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (en && byteEn != 4'b0000) begin
            mem[wordAddr] <= merged;
        end
    end

    assign storeReport = '{wordAddr: wordAddr, byteEn: byteEn, data: merged};

    // sign extended load lanes
    assign ldByte = rdWord[{addr[1:0], 3'b000} +: 8];
    assign ldHalf = rdWord[{addr[1], 4'b0000} +: 16];

    always_comb begin
        case (loadSize)
            mipsPkg::accByte: loadData = {{24{ldByte[7]}}, ldByte};
            mipsPkg::accHalf: loadData = {{16{ldHalf[15]}}, ldHalf};
            mipsPkg::accWord: loadData = rdWord;
            default:          loadData = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== mipsCore.sv ====
`default_nettype none

module mipsCore (
    input  logic               clk,
    input  logic               rstN,
    input  logic               instrValid,
    input  mipsPkg::instrT     instr,
    output logic               wbValid,
    output mipsPkg::wbReportT  wbReport,
    output logic               memValid,
    output mipsPkg::memReportT memReport
);

    mipsPkg::ctrlT      ctrl;
    mipsPkg::memReportT storeReport;
    logic [31:0] rsData;
    logic [31:0] rtData;
    logic [31:0] extImm;
    logic [31:0] aluB;
    logic [31:0] aluY;
    logic [31:0] hiLoOut;
    logic [31:0] loadData;
    logic [31:0] wbData;
    logic        regWe;

    instrDecoder uDecoder (
        .instr (instr),
        .ctrl  (ctrl)
    );

    assign regWe = instrValid & ctrl.regWrite;

    regFile uRegFile (
        .clk    (clk),
        .rstN   (rstN),
        .we     (regWe),
        .waddr  (ctrl.regAddr),
        .wdata  (wbData),
        .raddrA (instr.r.rs),
        .raddrB (instr.r.rt),
        .rdataA (rsData),
        .rdataB (rtData)
    );

    always_comb begin
        case (ctrl.extOp)
            mipsPkg::extSign:  extImm = {{16{instr.i.imm16[15]}}, instr.i.imm16};
            mipsPkg::extUpper: extImm = {instr.i.imm16, 16'd0};
            default:           extImm = {16'd0, instr.i.imm16};
        endcase
    end

    assign aluB = ctrl.aluSrcImm ? extImm : rtData;

    aluUnit uAlu (
        .op    (ctrl.aluOp),
        .a     (rsData),
        .b     (aluB),
        .shamt (instr.r.shamt),
        .y     (aluY)
    );

    mulDivUnit uMdu (
        .clk     (clk),
        .rstN    (rstN),
        .en      (instrValid),
        .op      (ctrl.mduOp),
        .a       (rsData),
        .b       (rtData),
        .hiLoOut (hiLoOut)
    );

    // alu output carries rs + signed offset for loads and stores
    dataMem uDataMem (
        .clk         (clk),
        .en          (instrValid),
        .addr        (aluY),
        .wdata       (rtData),
        .storeSize   (ctrl.storeSize),
        .loadSize    (ctrl.loadSize),
        .loadData    (loadData),
        .storeReport (storeReport)
    );

    always_comb begin
        case (ctrl.wbSrc)
            mipsPkg::wbMem: wbData = loadData;
            mipsPkg::wbExt: wbData = extImm;
            mipsPkg::wbMdu: wbData = hiLoOut;
            default:        wbData = aluY;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbValid  <= 1'b0;
            memValid <= 1'b0;
        end else begin
            wbValid  <= regWe && ctrl.regAddr != 5'd0;
            memValid <= instrValid & ctrl.memWrite;
        end
    end

    // report payloads
    always_ff @(posedge clk) begin
        if (regWe) begin
            wbReport <= '{addr: ctrl.regAddr, data: wbData};
        end
        if (instrValid && ctrl.memWrite) begin
            memReport <= storeReport;
        end
    end

endmodule

`default_nettype wire

// ==== mipsCore_tb.sv ====
`default_nettype none

`include "mipsCore_config.svh"

module mipsCore_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int maxTests = 64;
    localparam int fieldsPerTest = 5;
    localparam int reportTimeout = 8;
    localparam int quietCycles = 3;

    logic               clk;
    logic               rstN;
    logic               instrValid;
    mipsPkg::instrT     instr;
    logic               wbValid;
    mipsPkg::wbReportT  wbReport;
    logic               memValid;
    mipsPkg::memReportT memReport;

    logic [31:0] testWords [maxTests * fieldsPerTest];
    int          testCount;

    mipsCore dut0 (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .wbValid    (wbValid),
        .wbReport   (wbReport),
        .memValid   (memValid),
        .memReport  (memReport)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic stopRun();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic checkWb(input mipsPkg::wbReportT expected, input mipsPkg::wbReportT actual);
        if (actual !== expected) begin
            $write("CHECK FAILED time=%0t signal=wbReport", $time);
            $display(" expected addr=%0d data=%08h actual addr=%0d data=%08h",
                     expected.addr, expected.data, actual.addr, actual.data);
            stopRun();
        end
    endtask

    task automatic checkMem(input mipsPkg::memReportT expected,
                            input mipsPkg::memReportT actual);
        if (actual !== expected) begin
            $write("CHECK FAILED time=%0t signal=memReport", $time);
            $display(" expected word=%0d en=%04b data=%08h actual word=%0d en=%04b data=%08h",
                     expected.wordAddr, expected.byteEn, expected.data,
                     actual.wordAddr, actual.byteEn, actual.data);
            stopRun();
        end
    endtask

    // sampled at falling edges away from the register updates
    task automatic expectWb(input mipsPkg::wbReportT expected);
        int n;
        n = 0;
        while (!wbValid && !memValid && n < reportTimeout) begin
            @(negedge clk);
            n++;
        end
        if (memValid) begin
            $display("ERROR at %0t: memory write reported where a register write was due",
                     $time);
            stopRun();
        end
        if (!wbValid) begin
            $display("ERROR at %0t: no register write report within %0d cycles",
                     $time, reportTimeout);
            stopRun();
        end
        checkWb(expected, wbReport);
    endtask

    task automatic expectMem(input mipsPkg::memReportT expected);
        int n;
        n = 0;
        while (!wbValid && !memValid && n < reportTimeout) begin
            @(negedge clk);
            n++;
        end
        if (wbValid) begin
            $display("ERROR at %0t: register write reported where a memory write was due",
                     $time);
            stopRun();
        end
        if (!memValid) begin
            $display("ERROR at %0t: no memory write report within %0d cycles",
                     $time, reportTimeout);
            stopRun();
        end
        checkMem(expected, memReport);
    endtask

    // nothing may show up on either port for a while
    task automatic expectQuiet();
        for (int n = 0; n < quietCycles; n++) begin
            if (wbValid || memValid) begin
                $display("ERROR at %0t: a report appeared for an instruction with no result",
                         $time);
                stopRun();
            end
            @(negedge clk);
        end
    endtask

    initial begin
        int                 base;
        mipsPkg::wbReportT  expWb;
        mipsPkg::memReportT expMem;

        $timeformat(-9, 0, " ns", 0);
        rstN = 1'b0;
        instrValid = 1'b0;
        instr = '0;

        $readmemh("mipsCore_tests.txt", testWords);
        testCount = -1;
        for (int t = 0; t < maxTests && testCount < 0; t++) begin
            if (testWords[t * fieldsPerTest + 1] == 32'hf) begin
                testCount = t;
            end
        end
        if (testCount <= 0) begin
            $display("ERROR: the tests file holds no tests or lacks its end line");
            stopRun();
        end

        repeat (10) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        expectQuiet();

        for (int t = 0; t < testCount; t++) begin
            base = t * fieldsPerTest;
            instr = testWords[base];
            instrValid = 1'b1;
            @(negedge clk);
            instrValid = 1'b0;
            case (testWords[base + 1])
                32'd0: expectQuiet();
                32'd1: begin
                    expWb = '{addr: testWords[base + 2][4:0], data: testWords[base + 4]};
                    expectWb(expWb);
                end
                32'd2: begin
                    expMem = '{wordAddr: testWords[base + 2][`MIPS_DMEM_AW-1:0],
                               byteEn: testWords[base + 3][3:0],
                               data: testWords[base + 4]};
                    expectMem(expMem);
                end
                default: begin
                    $display("ERROR: test %0d has an unknown report kind", t);
                    stopRun();
                end
            endcase
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mipsCore_tests.txt ====
// columns: instruction, kind (0 none, 1 register write, 2 memory write, f end),
// address (register or word), byte enables, data
20010005 1 01 0 00000005 // addi $1, $0, 5
2002fffd 1 02 0 fffffffd // addi $2, $0, -3
3c038000 1 03 0 80000000 // lui $3, 0x8000
34631234 1 03 0 80001234 // ori $3, $3, 0x1234
00222020 1 04 0 00000002 // add $4, $1, $2
00222822 1 05 0 00000008 // sub $5, $1, $2
00433024 1 06 0 80001234 // and $6, $2, $3
00233825 1 07 0 80001235 // or $7, $1, $3
00414026 1 08 0 fffffff8 // xor $8, $2, $1
00014900 1 09 0 00000050 // sll $9, $1, 4
0041502a 1 0a 0 00000001 // slt $10, $2, $1
0041582b 1 0b 0 00000000 // sltu $11, $2, $1
0022682b 1 0d 0 00000001 // sltu $13, $1, $2
20200007 0 00 0 00000000 // addi $0, $1, 7
00017020 1 0e 0 00000005 // add $14, $0, $1
00410018 0 00 0 00000000 // mult $2, $1
00007810 1 0f 0 ffffffff // mfhi $15
00008012 1 10 0 fffffff1 // mflo $16
00410019 0 00 0 00000000 // multu $2, $1
00007810 1 0f 0 00000004 // mfhi $15
00a2001a 0 00 0 00000000 // div $5, $2
00008012 1 10 0 fffffffe // mflo $16
00008810 1 11 0 00000002 // mfhi $17
0041001b 0 00 0 00000000 // divu $2, $1
00008012 1 10 0 33333332 // mflo $16
00600011 0 00 0 00000000 // mthi $3
01000013 0 00 0 00000000 // mtlo $8
00009010 1 12 0 80001234 // mfhi $18
00009812 1 13 0 fffffff8 // mflo $19
00250018 0 00 0 00000000 // mult $1, $5
70410000 0 00 0 00000000 // madd $2, $1
0000a012 1 14 0 00000019 // mflo $20
70250004 0 00 0 00000000 // msub $1, $5
0000a810 1 15 0 ffffffff // mfhi $21
ac030010 2 04 f 80001234 // sw $3, 16($0)
a0080011 2 04 2 8000f834 // sb $8, 17($0)
a4020012 2 04 c fffdf834 // sh $2, 18($0)
8c160010 1 16 0 fffdf834 // lw $22, 16($0)
80170011 1 17 0 fffffff8 // lb $23, 17($0)
84190012 1 19 0 fffffffd // lh $25, 18($0)
10210004 0 00 0 00000000 // beq $1, $1, 4
00000000 f 00 0 00000000 // end of tests

// ==== mipsCore.f ====
+incdir+.
mipsPkg.sv
instrDecoder.sv
regFile.sv
aluUnit.sv
mulDivUnit.sv
dataMem.sv
mipsCore.sv
mipsCore_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the mipsCore testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator was not found in PATH"
    exit 1
fi

verilator --binary --timing -f mipsCore.f --top-module mipsCore_tb -o mipsCore_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/mipsCore_sim 2>&1)
simStatus=$?
echo "$simOut"

if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOut" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1
